/* fetch_pkg.sv */
package fetch_pkg;

	// ##########################################################
	// address and instruction words
	// ##########################################################

	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	localparam addr_t reset_pc = 32'h3000_0000;    // first instruction after reset

	// ##########################################################
	// cache geometry
	// ##########################################################

	localparam int words_per_line = 8;
	localparam int line_count = 16;

	typedef logic [2:0] offset_t;    // address bits 4:2
	typedef logic [3:0] index_t;     // address bits 8:5
	typedef logic [22:0] tag_t;      // address bits 31:9

	typedef enum logic [1:0] {
		lookup,
		request,
		refill,
		resume
	} fetch_state_t;

	function automatic offset_t offset_of(addr_t addr);
		return addr[4:2];
	endfunction

	function automatic index_t index_of(addr_t addr);
		return addr[8:5];
	endfunction

	function automatic tag_t tag_of(addr_t addr);
		return addr[31:9];
	endfunction

endpackage

/* bus_pkg.sv */
package bus_pkg;

	localparam int burst_beats = 8;    // one beat per word of a cache line

	// read address channel, held until ar_ready
	typedef struct packed {
		logic [31:0] addr;     // always line aligned
		logic        valid;
	} read_req_t;

	// read data channel, one word per beat
	typedef struct packed {
		logic [31:0] data;
		logic        valid;
		logic        last;     // set on the final beat of the burst
	} read_rsp_t;

endpackage

/* icache.sv */
`timescale 1ns/1ps

module icache (
	input  logic             clock,
	input  logic             reset,
	input  fetch_pkg::addr_t lookup_pc,
	output logic             hit,
	output fetch_pkg::word_t hit_data,
	input  logic             fill_valid,
	input  fetch_pkg::addr_t fill_pc,
	input  fetch_pkg::word_t fill_data
);

	fetch_pkg::tag_t tag_array [fetch_pkg::line_count];
	logic [fetch_pkg::line_count-1:0] valid_array;
	fetch_pkg::word_t data_array [fetch_pkg::line_count][fetch_pkg::words_per_line];

	fetch_pkg::addr_t look_addr;
	fetch_pkg::word_t read_word;

	fetch_pkg::fetch_state_t fill_state;
	fetch_pkg::tag_t fill_tag;
	fetch_pkg::index_t fill_index;

	fetch_pkg::index_t look_index;
	fetch_pkg::index_t fill_slot;
	logic fill_first;
	logic fill_last;

	assign look_index = fetch_pkg::index_of(look_addr);
	assign fill_slot = fetch_pkg::index_of(fill_pc);
	assign fill_first = fill_valid && (fill_state == fetch_pkg::lookup);
	assign fill_last = fill_valid &&
		(fetch_pkg::offset_of(fill_pc) == fetch_pkg::offset_t'(fetch_pkg::words_per_line - 1));

	// ##########################################################
	// registered lookup
	// ##########################################################

	always_ff @(posedge clock) begin
		look_addr <= lookup_pc;
		read_word <= data_array[fetch_pkg::index_of(lookup_pc)][fetch_pkg::offset_of(lookup_pc)];
	end

	assign hit = valid_array[look_index] && (tag_array[look_index] == fetch_pkg::tag_of(look_addr));
	assign hit_data = read_word;

	// ##########################################################
	// line refill
	// ##########################################################

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_array[fill_slot][fetch_pkg::offset_of(fill_pc)] <= fill_data;
		end
		if (fill_last) begin
			tag_array[fill_slot] <= fetch_pkg::tag_of(fill_pc);
		end
		if (fill_first) begin
			fill_tag <= fetch_pkg::tag_of(fill_pc);    // remembered to check the rest of the burst
			fill_index <= fill_slot;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_array <= '0;
			fill_state <= fetch_pkg::lookup;
		end else if (fill_valid) begin
			if (fill_last) begin
				valid_array[fill_slot] <= 1'b1;    // line is complete
				fill_state <= fetch_pkg::lookup;
			end else begin
				fill_state <= fetch_pkg::refill;
				if (fill_first) begin
					valid_array[fill_slot] <= 1'b0;    // old contents are being overwritten
				end
			end
		end
	end

	// every pulse after the first of a burst stays in the same line
	fill_in_one_line: assert property (@(posedge clock) disable iff (reset)
		fill_valid && (fill_state == fetch_pkg::refill) |->
			(fetch_pkg::tag_of(fill_pc) == fill_tag) &&
			(fetch_pkg::index_of(fill_pc) == fill_index));

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic               clock,
	input  logic               reset,
	output fetch_pkg::addr_t   lookup_pc,
	input  logic               hit,
	input  fetch_pkg::word_t   hit_data,
	output logic               fill_valid,
	output fetch_pkg::addr_t   fill_pc,
	output fetch_pkg::word_t   fill_data,
	output bus_pkg::read_req_t bus_req,
	input  logic               bus_ar_ready,
	input  bus_pkg::read_rsp_t bus_rsp,
	output logic               bus_r_ready,
	input  logic               redirect,
	input  fetch_pkg::addr_t   redirect_pc,
	output logic               inst_valid,
	output fetch_pkg::word_t   inst,
	output fetch_pkg::addr_t   inst_pc,
	input  logic               inst_ready
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::addr_t pc;                 // address presented to the cache
	fetch_pkg::addr_t look_pc;            // address the cache is answering for
	logic look_valid;
	logic req_valid;
	fetch_pkg::addr_t req_addr;
	fetch_pkg::offset_t beat_count;
	fetch_pkg::word_t held_word;
	logic redirect_pending;
	fetch_pkg::addr_t redirect_target;

	logic out_free;
	logic beat;
	logic in_lookup;
	logic take_hit;
	logic take_miss;
	logic issue;
	logic deliver;

	assign out_free = !inst_valid || inst_ready;
	assign beat = bus_rsp.valid && bus_r_ready;
	assign in_lookup = (state == fetch_pkg::lookup) && !redirect;
	assign take_hit = in_lookup && look_valid && hit && out_free;
	assign take_miss = in_lookup && look_valid && !hit;
	assign issue = in_lookup && !take_miss && out_free;
	assign deliver = (state == fetch_pkg::resume) && !redirect && !redirect_pending && out_free;

	assign lookup_pc = pc;
	assign bus_req.addr = req_addr;
	assign bus_req.valid = req_valid;
	assign fill_valid = beat;
	assign fill_pc = {req_addr[31:5], beat_count, 2'b00};
	assign fill_data = bus_rsp.data;

	// ##########################################################
	// control
	// ##########################################################

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_pkg::lookup;
			pc <= fetch_pkg::reset_pc;
			look_valid <= 1'b0;
			req_valid <= 1'b0;
			bus_r_ready <= 1'b0;
			beat_count <= '0;
			redirect_pending <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			if ((inst_valid && inst_ready) || redirect) begin
				inst_valid <= 1'b0;    // handed on, or dropped by a redirect
			end
			case (state)
				fetch_pkg::lookup: begin
					if (redirect) begin
						pc <= redirect_pc;
						look_valid <= 1'b0;
					end else if (take_miss) begin
						state <= fetch_pkg::request;
						req_valid <= 1'b1;
						pc <= look_pc;    // refetch this address once the line is in
						look_valid <= 1'b0;
					end else if (issue) begin
						pc <= pc + 32'd4;
						look_valid <= 1'b1;
						if (take_hit) begin
							inst_valid <= 1'b1;
						end
					end else if (look_valid) begin
						pc <= look_pc;    // hit arrived while the output was full, ask again later
						look_valid <= 1'b0;
					end
				end
				fetch_pkg::request: begin
					if (bus_ar_ready) begin
						state <= fetch_pkg::refill;
						req_valid <= 1'b0;
						bus_r_ready <= 1'b1;
						beat_count <= '0;
					end
				end
				fetch_pkg::refill: begin
					if (beat) begin
						beat_count <= beat_count + 3'd1;
						if (bus_rsp.last) begin
							state <= fetch_pkg::resume;
							bus_r_ready <= 1'b0;
						end
					end
				end
				fetch_pkg::resume: begin
					if (redirect) begin
						pc <= redirect_pc;
						redirect_pending <= 1'b0;
						state <= fetch_pkg::lookup;
					end else if (redirect_pending) begin
						pc <= redirect_target;
						redirect_pending <= 1'b0;
						state <= fetch_pkg::lookup;
					end else if (out_free) begin
						inst_valid <= 1'b1;
						pc <= pc + 32'd4;
						state <= fetch_pkg::lookup;
					end
				end
				default: begin
					state <= fetch_pkg::lookup;
				end
			endcase
			if (redirect && ((state == fetch_pkg::request) || (state == fetch_pkg::refill))) begin
				redirect_pending <= 1'b1;    // the burst runs to its end first
			end
		end
	end

	// ##########################################################
	// payload registers
	// ##########################################################

	always_ff @(posedge clock) begin
		if (issue) begin
			look_pc <= pc;
		end
		if (take_hit) begin
			inst <= hit_data;
			inst_pc <= look_pc;
		end else if (deliver) begin
			inst <= held_word;
			inst_pc <= pc;
		end
		if (take_miss) begin
			req_addr <= {look_pc[31:5], 5'b0_0000};
		end
		if (beat && (beat_count == fetch_pkg::offset_of(pc)) && !redirect_pending) begin
			held_word <= bus_rsp.data;    // the word that missed
		end
		if (redirect) begin
			redirect_target <= redirect_pc;
		end
	end

	// ##########################################################
	// protocol checks
	// ##########################################################

	req_held: assert property (@(posedge clock) disable iff (reset)
		req_valid && !bus_ar_ready |=> req_valid && $stable(req_addr));

	out_held: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=>
			inst_valid && $stable(inst) && $stable(inst_pc));

	// last comes with the eighth beat and never before
	last_on_eighth: assert property (@(posedge clock) disable iff (reset)
		beat |-> bus_rsp.last == (beat_count == fetch_pkg::offset_t'(bus_pkg::burst_beats - 1)));

endmodule

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
	input  logic               clock,
	input  logic               reset,
	output bus_pkg::read_req_t bus_req,
	input  logic               bus_ar_ready,
	input  bus_pkg::read_rsp_t bus_rsp,
	output logic               bus_r_ready,
	input  logic               redirect,
	input  fetch_pkg::addr_t   redirect_pc,
	output logic               inst_valid,
	output fetch_pkg::word_t   inst,
	output fetch_pkg::addr_t   inst_pc,
	input  logic               inst_ready
);

	fetch_pkg::addr_t lookup_pc;
	logic hit;
	fetch_pkg::word_t hit_data;
	logic fill_valid;
	fetch_pkg::addr_t fill_pc;
	fetch_pkg::word_t fill_data;

	fetch_unit unit (
		.clock        (clock),
		.reset        (reset),
		.lookup_pc    (lookup_pc),
		.hit          (hit),
		.hit_data     (hit_data),
		.fill_valid   (fill_valid),
		.fill_pc      (fill_pc),
		.fill_data    (fill_data),
		.bus_req      (bus_req),
		.bus_ar_ready (bus_ar_ready),
		.bus_rsp      (bus_rsp),
		.bus_r_ready  (bus_r_ready),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_pc      (inst_pc),
		.inst_ready   (inst_ready)
	);

	icache cache (
		.clock      (clock),
		.reset      (reset),
		.lookup_pc  (lookup_pc),
		.hit        (hit),
		.hit_data   (hit_data),
		.fill_valid (fill_valid),
		.fill_pc    (fill_pc),
		.fill_data  (fill_data)
	);

endmodule

/* tb_memory.sv */
`timescale 1ns/1ps

module tb_memory (
	input  logic               clock,
	input  logic               reset,
	input  bus_pkg::read_req_t req,
	output logic               ar_ready,
	output bus_pkg::read_rsp_t rsp,
	input  logic               r_ready,
	input  logic [3:0]         max_delay,
	output logic               busy,
	output int                 burst_count
);

	logic [31:0] seed = 32'h0b06_3e6b;
	int wait_count;
	int beat_index;
	logic [31:0] base_addr;

	function automatic logic [31:0] mem_word(logic [31:0] addr);
		return (addr ^ 32'h5a5a_0000) | 32'h0000_0003;
	endfunction

	function automatic int pick_delay();
		logic [31:0] draw;
		draw = $random(seed);
		return int'(draw % (32'(max_delay) + 32'd1));
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			ar_ready <= 1'b0;
			rsp <= '0;
			busy <= 1'b0;
			beat_index <= 0;
			base_addr <= '0;
			burst_count <= 0;
			wait_count <= 0;
		end else if (!busy) begin
			if (req.valid && ar_ready) begin
				ar_ready <= 1'b0;    // address taken on this edge
				busy <= 1'b1;
				base_addr <= req.addr;
				beat_index <= 0;
				burst_count <= burst_count + 1;
				wait_count <= pick_delay();
			end else if (req.valid && (wait_count == 0)) begin
				ar_ready <= 1'b1;
			end else if (req.valid) begin
				wait_count <= wait_count - 1;
			end
		end else if (!rsp.valid || r_ready) begin
			if (rsp.valid && rsp.last) begin
				rsp <= '0;    // burst complete
				busy <= 1'b0;
				wait_count <= pick_delay();
			end else if (wait_count != 0) begin
				rsp.valid <= 1'b0;
				wait_count <= wait_count - 1;
			end else begin
				rsp.data <= mem_word(base_addr + 32'(beat_index * 4));
				rsp.valid <= 1'b1;
				rsp.last <= (beat_index == bus_pkg::burst_beats - 1);
				beat_index <= beat_index + 1;
				wait_count <= pick_delay();
			end
		end
	end

endmodule

/* tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch;

	// test 4 allows for the transfers that pass before its refill starts
	localparam int planned_transfers = 24 + 24 + 40 + 8 + 20 * 3;
	localparam int timeout_cycles = planned_transfers * 40;

	logic clock;
	logic reset;
	bus_pkg::read_req_t bus_req;
	logic bus_ar_ready;
	bus_pkg::read_rsp_t bus_rsp;
	logic bus_r_ready;
	logic redirect;
	fetch_pkg::addr_t redirect_pc;
	logic inst_valid;
	fetch_pkg::word_t inst;
	fetch_pkg::addr_t inst_pc;
	logic inst_ready;
	logic [3:0] max_delay;
	logic mem_busy;
	int burst_count;

	logic [31:0] seed = 32'h0b06_3e6b;
	logic random_ready = 1'b0;
	fetch_pkg::addr_t expected_pc = fetch_pkg::reset_pc;
	fetch_pkg::addr_t last_pc;
	fetch_pkg::word_t held_inst;
	fetch_pkg::addr_t held_pc;
	logic hold_seen = 1'b0;
	int transfer_count = 0;
	int error_count = 0;

	fetch_top DUT (
		.clock        (clock),
		.reset        (reset),
		.bus_req      (bus_req),
		.bus_ar_ready (bus_ar_ready),
		.bus_rsp      (bus_rsp),
		.bus_r_ready  (bus_r_ready),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_pc      (inst_pc),
		.inst_ready   (inst_ready)
	);

	tb_memory memory (
		.clock       (clock),
		.reset       (reset),
		.req         (bus_req),
		.ar_ready    (bus_ar_ready),
		.rsp         (bus_rsp),
		.r_ready     (bus_r_ready),
		.max_delay   (max_delay),
		.busy        (mem_busy),
		.burst_count (burst_count)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// ##########################################################
	// reference and checking
	// ##########################################################

	function automatic fetch_pkg::word_t expected_inst(fetch_pkg::addr_t addr);
		return {addr[31:16] ^ 16'h5a5a, addr[15:2], 2'b11};
	endfunction

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// sampled between edges, so each line describes the coming rising edge
	always @(negedge clock) begin
		if (reset) begin
			expected_pc = fetch_pkg::reset_pc;
			hold_seen = 1'b0;
		end else begin
			if (hold_seen) begin
				check_value("inst_valid", inst_valid, 1'b1);
				check_value("inst", inst, held_inst);
				check_value("inst_pc", inst_pc, held_pc);
			end
			if (redirect) begin
				expected_pc = redirect_pc;    // a waiting instruction is dropped
			end else if (inst_valid && inst_ready) begin
				check_value("inst_pc", inst_pc, expected_pc);
				check_value("inst", inst, expected_inst(expected_pc));
				last_pc = inst_pc;
				expected_pc = expected_pc + 32'd4;
				transfer_count++;
			end
			hold_seen = inst_valid && !inst_ready && !redirect;
			held_inst = inst;
			held_pc = inst_pc;
		end
	end

	// ##########################################################
	// stimulus helpers
	// ##########################################################

	task automatic next_cycle();
		@(posedge clock);
		if (random_ready) begin
			inst_ready <= (next_random() % 2) == 32'd1;
		end
	endtask

	task automatic wait_transfers(input int count);
		int target;
		target = transfer_count + count;
		while (transfer_count < target) begin
			next_cycle();
		end
	endtask

	// fetch has stopped with a full output register and an idle bus
	task automatic wait_stall();
		int quiet;
		quiet = 0;
		while (quiet < 3) begin
			@(negedge clock);
			quiet = (inst_valid && !bus_req.valid && !mem_busy) ? quiet + 1 : 0;
		end
		next_cycle();
	endtask

	// returns on the edge that accepts a burst request
	task automatic wait_accept();
		do begin
			next_cycle();
			@(negedge clock);
		end while (!(bus_req.valid && bus_ar_ready));
		next_cycle();
	endtask

	task automatic send_redirect(input fetch_pkg::addr_t target);
		redirect <= 1'b1;
		redirect_pc <= target;
		next_cycle();
		redirect <= 1'b0;
	endtask

	task automatic report_test(input int number, input string name, input int start_errors);
		$display("test %0d, %s: finished with %0d errors", number, name,
			error_count - start_errors);
	endtask

	// ##########################################################
	// tests
	// ##########################################################

	initial begin : watchdog
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run stalled after %0d cycles and %0d transfers",
			cycle_count, transfer_count);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		fetch_pkg::addr_t target;
		int snapshot;
		int start_errors;
		reset <= 1'b1;
		redirect <= 1'b0;
		redirect_pc <= '0;
		inst_ready <= 1'b0;
		max_delay <= 4'd0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		inst_ready <= 1'b1;

		start_errors = error_count;
		wait_transfers(24);
		check_value("burst_count", burst_count, 3);    // one refill per line
		inst_ready <= 1'b0;
		report_test(1, "sequential fetch from reset", start_errors);

		start_errors = error_count;
		wait_stall();
		snapshot = burst_count;
		inst_ready <= 1'b1;
		send_redirect(fetch_pkg::reset_pc);
		wait_transfers(24);
		check_value("burst_count", burst_count, snapshot);
		report_test(2, "refetch of cached lines", start_errors);

		start_errors = error_count;
		max_delay <= 4'd3;
		random_ready = 1'b1;
		wait_transfers(40);
		report_test(3, "random back-pressure and delays", start_errors);

		start_errors = error_count;
		target = fetch_pkg::reset_pc + 32'h0000_0800;    // same index as reset_pc, other tag
		wait_accept();
		send_redirect(target);
		wait_transfers(1);
		check_value("inst_pc", last_pc, target);
		report_test(4, "redirect during refill", start_errors);

		start_errors = error_count;
		repeat (20) begin
			target = fetch_pkg::reset_pc + (next_random() & 32'h0000_0ffc);
			send_redirect(target);
			wait_transfers(1 + int'(next_random() % 3));
			repeat (next_random() % 4) next_cycle();
		end
		report_test(5, "random redirects", start_errors);

		$display("5 tests run, %0d transfers checked, %0d errors", transfer_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* tb.f */
fetch_pkg.sv
bus_pkg.sv
icache.sv
fetch_unit.sv
fetch_top.sv
tb_memory.sv
tb_fetch.sv

/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - fetch_pkg.sv
  - bus_pkg.sv
  - icache.sv
  - fetch_unit.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_memory.sv
      - tb_fetch.sv
